// File: src/conv_ctrl_pkg.sv
package conv_ctrl_pkg;

    // ======================================================================
    // Widths
    // ======================================================================
    localparam int N_W   = 7;   // Matrix size N
    localparam int K_W   = 5;   // Kernel size K
    localparam int CNT_W = 16;  // Beat and cycle counters

    // ======================================================================
    // Controller states
    // ======================================================================
    typedef enum logic [2:0] {
        S_IDLE         = 3'd0,
        S_LOAD_WEIGHTS = 3'd1,
        S_LOAD_INPUT   = 3'd2,
        S_COMPUTE      = 3'd3,
        S_DRAIN        = 3'd4,
        S_DONE         = 3'd5
    } ctrl_state_e;

    // AGU operating modes
    typedef enum logic [2:0] {
        AGU_IDLE        = 3'd0,
        AGU_LOAD_WEIGHT = 3'd1,
        AGU_LOAD_INPUT  = 3'd2,
        AGU_SLIDING_WIN = 3'd3,
        AGU_UNLOAD      = 3'd4
    } agu_mode_e;

    // ======================================================================
    // Control structs
    // ======================================================================

    // Latched job, totals derived at accept
    typedef struct packed {
        logic [N_W-1:0]   n;
        logic [K_W-1:0]   k;
        logic [CNT_W-1:0] total_weights;  // K*K
        logic [CNT_W-1:0] total_outputs;  // (N-K+1)^2
    } job_cfg_t;

    typedef struct packed {
        agu_mode_e mode;
        logic      start;   // One-cycle pulse per state entry
    } agu_ctrl_t;

    typedef struct packed {
        logic write_en;     // Stream beat into SRAM
        logic read_en;      // Results out of SRAM
        logic bank_sel;     // Input ping-pong bank
    } mem_ctrl_t;

    typedef struct packed {
        logic clear;        // Accumulator clear, once per job
        logic load_weight;
        logic mem_read;
        logic mem_write;
    } sa_ctrl_t;

endpackage

// File: src/job_config.sv
`timescale 1ns/1ns

module job_config import conv_ctrl_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           accept,   // Job taken by FSM this cycle
    input  logic [N_W-1:0] cfg_n,
    input  logic [K_W-1:0] cfg_k,
    output job_cfg_t       job
);

    // ======================================================================
    // Totals from the raw host config
    // ======================================================================
    logic [N_W-1:0]   out_dim;        // N-K+1, side of output map
    logic [CNT_W-1:0] weights_calc;
    logic [CNT_W-1:0] outputs_calc;

    assign out_dim      = cfg_n - N_W'(cfg_k) + N_W'(1);
    assign weights_calc = CNT_W'(cfg_k) * CNT_W'(cfg_k);    // K*K beats
    assign outputs_calc = CNT_W'(out_dim) * CNT_W'(out_dim);

    // Held for the whole job, only reloaded on accept
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            job <= '0;
        end else if (accept) begin
            job.n             <= cfg_n;
            job.k             <= cfg_k;
            job.total_weights <= weights_calc;
            job.total_outputs <= outputs_calc;
        end
    end

endmodule

// File: src/stream_counters.sv
`timescale 1ns/1ns

module stream_counters import conv_ctrl_pkg::*; #(
    parameter int ARRAY_SIZE = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  ctrl_state_e state,
    input  logic        state_entry,
    input  job_cfg_t    job,
    input  logic        rx_valid,
    input  logic        rx_ready,
    input  logic        tx_valid,
    input  logic        tx_ready,
    output logic        weights_done,   // Last weight beat this cycle
    output logic        tile_loaded,    // Last input beat this cycle
    output logic        tile_drained,   // Current tile owes nothing more
    output logic        job_drained,    // All job outputs sent
    output logic        last_tile,      // Remaining outputs fit in one tile
    output logic        weight_beat,
    output logic        input_beat
);

    localparam logic [CNT_W-1:0] TILE_INPUTS  = CNT_W'(ARRAY_SIZE * ARRAY_SIZE);
    localparam logic [CNT_W-1:0] TILE_OUTPUTS = CNT_W'(ARRAY_SIZE * ARRAY_SIZE);

    logic [CNT_W-1:0] weight_cnt;
    logic [CNT_W-1:0] in_cnt;       // Per tile
    logic [CNT_W-1:0] out_cnt;      // Per tile
    logic [CNT_W-1:0] out_total;    // Whole job
    logic [CNT_W-1:0] outputs_left; // Owed at start of current tile
    logic [CNT_W-1:0] tile_owed;
    logic             tx_beat;

    // ======================================================================
    // Beat strobes
    // ======================================================================
    assign weight_beat = rx_valid && rx_ready && (state == S_LOAD_WEIGHTS);
    assign input_beat  = rx_valid && rx_ready && (state == S_LOAD_INPUT);
    assign tx_beat     = tx_valid && tx_ready;

    // Adding back out_cnt keeps this steady across the drain
    assign outputs_left = job.total_outputs - out_total + out_cnt;
    assign tile_owed    = (outputs_left < TILE_OUTPUTS) ? outputs_left : TILE_OUTPUTS;

    // ======================================================================
    // Phase completion
    // ======================================================================
    assign weights_done = weight_beat && (weight_cnt == job.total_weights - CNT_W'(1));
    assign tile_loaded  = input_beat && (in_cnt == TILE_INPUTS - CNT_W'(1));
    assign tile_drained = (out_cnt == tile_owed);
    assign job_drained  = (out_total >= job.total_outputs);
    assign last_tile    = (outputs_left <= TILE_OUTPUTS);

    // ======================================================================
    // Counters
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weight_cnt <= '0;
            in_cnt     <= '0;
            out_cnt    <= '0;
            out_total  <= '0;
        end else begin
            // Phase counters idle at zero outside their own state
            if (state != S_LOAD_WEIGHTS) weight_cnt <= '0;
            else if (weight_beat)        weight_cnt <= weight_cnt + CNT_W'(1);

            if (state != S_LOAD_INPUT) in_cnt <= '0;
            else if (input_beat)       in_cnt <= in_cnt + CNT_W'(1);

            if (state != S_DRAIN) out_cnt <= '0;
            else if (tx_beat)     out_cnt <= out_cnt + CNT_W'(1);

            // Job total restarts with the weight phase
            if (state_entry && state == S_LOAD_WEIGHTS) begin
                out_total <= '0;
            end else if (tx_beat) begin
                out_total <= out_total + CNT_W'(1);
            end
        end
    end

endmodule

// File: src/ctrl_fsm.sv
`timescale 1ns/1ns

module ctrl_fsm import conv_ctrl_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             host_req,
    input  logic             tile_ack,
    input  logic             weights_done,
    input  logic             tile_loaded,
    input  logic             tile_drained,
    input  logic             job_drained,
    input  logic             last_tile,
    output logic             accept,
    output ctrl_state_e      state,
    output logic             state_entry,   // First cycle of a new state
    output logic             host_ack,
    output logic             rx_ready,
    output logic             tx_valid,
    output logic             tile_req,
    output logic             last_tile_out,
    output logic [CNT_W-1:0] cycle_count
);

    ctrl_state_e next_state;

    // ======================================================================
    // Handshakes and stream gating
    // ======================================================================
    assign host_ack = (state == S_DONE);   // Held until host_req drops
    assign accept   = (state == S_IDLE) && host_req && !host_ack;

    assign rx_ready = (state == S_LOAD_WEIGHTS) || (state == S_LOAD_INPUT);
    assign tx_valid = (state == S_DRAIN) && !tile_drained;

    // Request held through COMPUTE, leaves on the ack edge
    assign tile_req      = (state == S_COMPUTE);
    assign last_tile_out = tile_req && last_tile;

    // ======================================================================
    // Next state
    // ======================================================================
    always_comb begin
        next_state = state;
        case (state)
            S_IDLE: begin
                if (accept) next_state = S_LOAD_WEIGHTS;
            end
            S_LOAD_WEIGHTS: begin
                if (weights_done) next_state = S_LOAD_INPUT;
            end
            S_LOAD_INPUT: begin
                if (tile_loaded) next_state = S_COMPUTE;
            end
            S_COMPUTE: begin
                if (tile_ack) next_state = S_DRAIN;
            end
            S_DRAIN: begin
                // Wait for array to drop ack as well
                if (tile_drained && !tile_ack) begin
                    next_state = job_drained ? S_DONE : S_LOAD_INPUT;
                end
            end
            S_DONE: begin
                if (!host_req) next_state = S_IDLE;
            end
            default: next_state = S_IDLE;
        endcase
    end

    // ======================================================================
    // State register and entry strobe
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            state_entry <= 1'b0;
        end else begin
            state       <= next_state;
            state_entry <= (next_state != state);
        end
    end

    // Active cycle profiling, frozen in DONE
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_count <= '0;
        end else if (accept) begin
            cycle_count <= '0;
        end else if (state != S_IDLE && state != S_DONE) begin
            cycle_count <= cycle_count + CNT_W'(1);
        end
    end

endmodule

// File: src/datapath_ctrl_decode.sv
`timescale 1ns/1ns

module datapath_ctrl_decode import conv_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  ctrl_state_e state,
    input  logic        state_entry,
    input  logic        weight_beat,
    input  logic        input_beat,
    output agu_ctrl_t   agu,
    output mem_ctrl_t   mem,
    output sa_ctrl_t    sa
);

    agu_mode_e mode_dec;
    logic      first_tile;   // No bank swap before first input tile
    logic      start_state;  // States that kick the AGU

    // ======================================================================
    // Mode per state
    // ======================================================================
    always_comb begin
        case (state)
            S_LOAD_WEIGHTS: mode_dec = AGU_LOAD_WEIGHT;
            S_LOAD_INPUT:   mode_dec = AGU_LOAD_INPUT;
            S_COMPUTE:      mode_dec = AGU_SLIDING_WIN;
            S_DRAIN:        mode_dec = AGU_UNLOAD;
            default:        mode_dec = AGU_IDLE;
        endcase
    end

    assign start_state = (state == S_LOAD_WEIGHTS) || (state == S_LOAD_INPUT) ||
                         (state == S_COMPUTE) || (state == S_DRAIN);

    // ======================================================================
    // Registered controls, one cycle behind state
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            agu <= '{mode: AGU_IDLE, start: 1'b0};
            mem <= '0;
            sa  <= '0;
        end else begin
            agu.mode  <= mode_dec;
            agu.start <= state_entry && start_state;

            mem.write_en <= weight_beat || input_beat;   // One beat, one write
            mem.read_en  <= (state == S_DRAIN);

            sa.clear       <= state_entry && (state == S_LOAD_WEIGHTS);
            sa.load_weight <= weight_beat;
            sa.mem_read    <= (state == S_COMPUTE);
            sa.mem_write   <= (state == S_DRAIN);   // Results back to SRAM

            // Ping-pong bank
            if (state_entry && state == S_LOAD_WEIGHTS) begin
                mem.bank_sel <= 1'b0;                 // Job start
            end else if (state_entry && state == S_LOAD_INPUT && !first_tile) begin
                mem.bank_sel <= ~mem.bank_sel;
            end
        end
    end

    // First-tile flag, armed by each new job
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            first_tile <= 1'b1;
        end else if (state_entry && state == S_LOAD_WEIGHTS) begin
            first_tile <= 1'b1;
        end else if (state_entry && state == S_LOAD_INPUT) begin
            first_tile <= 1'b0;
        end
    end

endmodule

// File: src/conv_ctrl_top.sv
`timescale 1ns/1ns

module conv_ctrl_top import conv_ctrl_pkg::*; #(
    parameter int ARRAY_SIZE = 8    // Systolic array side
) (
    input  logic             clk,
    input  logic             rst_n,
    // Host
    input  logic             host_req,
    input  logic [N_W-1:0]   cfg_n,
    input  logic [K_W-1:0]   cfg_k,
    output logic             host_ack,
    // Streams
    input  logic             rx_valid,
    output logic             rx_ready,
    output logic             tx_valid,
    input  logic             tx_ready,
    // Tile handshake
    output logic             tile_req,
    output logic             last_tile,
    input  logic             tile_ack,
    // Datapath controls
    output agu_ctrl_t        agu,
    output mem_ctrl_t        mem,
    output sa_ctrl_t         sa,
    // Status
    output ctrl_state_e      state,
    output logic [CNT_W-1:0] cycle_count
);

    // ======================================================================
    // Internal wiring
    // ======================================================================
    job_cfg_t job;
    logic     accept;
    logic     state_entry;
    logic     weights_done;
    logic     tile_loaded;
    logic     tile_drained;
    logic     job_drained;
    logic     last_tile_flag;   // Ungated, from counters
    logic     weight_beat;
    logic     input_beat;

    job_config u_job_config (
        .clk    (clk),
        .rst_n  (rst_n),
        .accept (accept),
        .cfg_n  (cfg_n),
        .cfg_k  (cfg_k),
        .job    (job)
    );

    stream_counters #(
        .ARRAY_SIZE (ARRAY_SIZE)
    ) u_stream_counters (
        .clk          (clk),
        .rst_n        (rst_n),
        .state        (state),
        .state_entry  (state_entry),
        .job          (job),
        .rx_valid     (rx_valid),
        .rx_ready     (rx_ready),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready),
        .weights_done (weights_done),
        .tile_loaded  (tile_loaded),
        .tile_drained (tile_drained),
        .job_drained  (job_drained),
        .last_tile    (last_tile_flag),
        .weight_beat  (weight_beat),
        .input_beat   (input_beat)
    );

    ctrl_fsm u_ctrl_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .host_req      (host_req),
        .tile_ack      (tile_ack),
        .weights_done  (weights_done),
        .tile_loaded   (tile_loaded),
        .tile_drained  (tile_drained),
        .job_drained   (job_drained),
        .last_tile     (last_tile_flag),
        .accept        (accept),
        .state         (state),
        .state_entry   (state_entry),
        .host_ack      (host_ack),
        .rx_ready      (rx_ready),
        .tx_valid      (tx_valid),
        .tile_req      (tile_req),
        .last_tile_out (last_tile),
        .cycle_count   (cycle_count)
    );

    datapath_ctrl_decode u_datapath_ctrl_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .state       (state),
        .state_entry (state_entry),
        .weight_beat (weight_beat),
        .input_beat  (input_beat),
        .agu         (agu),
        .mem         (mem),
        .sa          (sa)
    );

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset released just after an edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// File: testbench/conv_ctrl_properties.sv
`timescale 1ns/1ns

module conv_ctrl_properties import conv_ctrl_pkg::*; (
    input logic             clk,
    input logic             rst_n,
    input logic             host_req,
    input logic             host_ack,
    input logic             tile_req,
    input logic             tile_ack,
    input agu_ctrl_t        agu,
    input ctrl_state_e      state,
    input logic [CNT_W-1:0] cycle_count
);

    int fail_count = 0;   // Read by the testbench top at the end

    // ======================================================================
    // Host handshake
    // ======================================================================
    host_ack_held: assert property (@(posedge clk) disable iff (!rst_n)
        host_ack && host_req |=> host_ack)
    else begin
        fail_count++;
        $error("host_ack fell while host_req was still high");
    end

    no_job_during_ack: assert property (@(posedge clk) disable iff (!rst_n)
        host_ack |=> state != S_LOAD_WEIGHTS)
    else begin
        fail_count++;
        $error("job started while host_ack was high");
    end

    // ======================================================================
    // Tile handshake
    // ======================================================================
    tile_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        tile_req && !tile_ack |=> tile_req)
    else begin
        fail_count++;
        $error("tile_req fell before tile_ack was seen");
    end

    req_drops_on_ack: assert property (@(posedge clk) disable iff (!rst_n)
        tile_req && tile_ack |=> !tile_req)
    else begin
        fail_count++;
        $error("tile_req still high after tile_ack was seen");
    end

    // Decoded controls and profiling
    agu_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        agu.start |=> !agu.start || agu.mode != $past(agu.mode))
    else begin
        fail_count++;
        $error("agu.start held without a new state");
    end

    count_frozen_in_done: assert property (@(posedge clk) disable iff (!rst_n)
        state == S_DONE |=> $stable(cycle_count))
    else begin
        fail_count++;
        $error("cycle_count moved while the job was done");
    end

endmodule

bind conv_ctrl_top conv_ctrl_properties u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .host_req    (host_req),
    .host_ack    (host_ack),
    .tile_req    (tile_req),
    .tile_ack    (tile_ack),
    .agu         (agu),
    .state       (state),
    .cycle_count (cycle_count)
);

// File: testbench/tb_conv_ctrl.sv
`timescale 1ns/1ns

module tb_conv_ctrl import conv_ctrl_pkg::*; ();

    localparam int ARRAY_SIZE = 8;
    localparam int TILE_SIZE  = ARRAY_SIZE * ARRAY_SIZE;  // Inputs and outputs per tile
    localparam int CLK_PERIOD = 10;
    localparam int NUM_JOBS   = 3;
    localparam int JOB_N [NUM_JOBS] = '{16, 10, 20};
    localparam int JOB_K [NUM_JOBS] = '{3, 3, 16};      // Last job, one partial tile

    logic             clk;
    logic             rst_n;
    logic             host_req;
    logic [N_W-1:0]   cfg_n;
    logic [K_W-1:0]   cfg_k;
    logic             host_ack;
    logic             rx_valid;
    logic             rx_ready;
    logic             tx_valid;
    logic             tx_ready;
    logic             tile_req;
    logic             last_tile;
    logic             tile_ack;
    agu_ctrl_t        agu;
    mem_ctrl_t        mem;
    sa_ctrl_t         sa;
    ctrl_state_e      state;
    logic [CNT_W-1:0] cycle_count;

    // Scoreboard, cleared while IDLE
    int          w_beats, in_beats, out_beats, tiles, tile_out, starts, clears, active;
    int          exp_tiles;
    int          checks = 0;
    int          errors = 0;
    int          ack_wait = 0;     // Array latency still to go
    integer      seed = 72;
    ctrl_state_e prev_state = S_IDLE;
    logic        prev_tile_req = 1'b0;
    logic        prev_rx_beat = 1'b0;   // Any input stream beat last cycle
    logic        prev_w_beat = 1'b0;    // Weight beat last cycle

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(2)) u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    conv_ctrl_top #(.ARRAY_SIZE(ARRAY_SIZE)) u_dut (
        .clk(clk), .rst_n(rst_n), .host_req(host_req), .cfg_n(cfg_n), .cfg_k(cfg_k),
        .host_ack(host_ack), .rx_valid(rx_valid), .rx_ready(rx_ready),
        .tx_valid(tx_valid), .tx_ready(tx_ready), .tile_req(tile_req),
        .last_tile(last_tile), .tile_ack(tile_ack), .agu(agu), .mem(mem), .sa(sa),
        .state(state), .cycle_count(cycle_count)
    );

    function automatic int outputs_for(input int n, input int k);
        return (n - k + 1) * (n - k + 1);
    endfunction

    function automatic int tiles_for(input int n, input int k);
        return (outputs_for(n, k) + TILE_SIZE - 1) / TILE_SIZE;   // Rounded up
    endfunction

    function automatic agu_mode_e mode_of(input ctrl_state_e s);
        case (s)
            S_LOAD_WEIGHTS: return AGU_LOAD_WEIGHT;
            S_LOAD_INPUT:   return AGU_LOAD_INPUT;
            S_COMPUTE:      return AGU_SLIDING_WIN;
            S_DRAIN:        return AGU_UNLOAD;
            default:        return AGU_IDLE;
        endcase
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // ======================================================================
    // Stream and array models, one random source
    // ======================================================================
    always @(posedge clk) begin
        #1;
        if (rst_n) begin
            rx_valid = ($random(seed) & 3) != 0;    // Roughly one stall in four
            tx_ready = ($random(seed) & 3) != 0;
            if (!tile_req) begin
                tile_ack = 1'b0;                    // Four-phase return
                ack_wait = $random(seed) & 7;
            end else if (ack_wait == 0) begin
                tile_ack = 1'b1;
            end else begin
                ack_wait = ack_wait - 1;
            end
        end
    end

    // ======================================================================
    // Monitor at mid-cycle, where outputs are settled
    // ======================================================================
    always @(negedge clk) begin
        if (rst_n) begin
            if (state == S_IDLE) begin
                w_beats   = 0;
                in_beats  = 0;
                out_beats = 0;
                tiles     = 0;
                tile_out  = 0;
                starts    = 0;
                clears    = 0;
                active    = 0;
            end
            if (rx_valid && rx_ready) begin
                if (state == S_LOAD_WEIGHTS) w_beats++;
                else in_beats++;
            end
            if (tx_valid && tx_ready) begin
                out_beats++;
                tile_out++;
            end
            if (tile_req && !prev_tile_req) begin   // New tile request
                if (tiles > 0) check_eq("tile_out", tile_out, TILE_SIZE);
                check_eq("mem.bank_sel", 32'(mem.bank_sel), tiles % 2);
                tile_out = 0;
                tiles++;
            end
            check_eq("last_tile", 32'(last_tile), 32'(tile_req && tiles == exp_tiles));
            if (agu.start) starts++;
            // Decoded controls reflect the previous cycle
            check_eq("agu.mode", 32'(agu.mode), 32'(mode_of(prev_state)));
            check_eq("mem.write_en", 32'(mem.write_en), 32'(prev_rx_beat));
            check_eq("sa.load_weight", 32'(sa.load_weight), 32'(prev_w_beat));
            check_eq("mem.read_en", 32'(mem.read_en), 32'(prev_state == S_DRAIN));
            check_eq("sa.mem_read", 32'(sa.mem_read), 32'(prev_state == S_COMPUTE));
            check_eq("sa.mem_write", 32'(sa.mem_write), 32'(prev_state == S_DRAIN));
            if (sa.clear) clears++;
            if (state != S_IDLE && state != S_DONE) active++;
            if (state == S_DONE) check_eq("cycle_count", 32'(cycle_count), active);
            prev_state    = state;
            prev_tile_req = tile_req;
            prev_rx_beat  = rx_valid && rx_ready;
            prev_w_beat   = rx_valid && rx_ready && (state == S_LOAD_WEIGHTS);
        end
    end

    // ======================================================================
    // Host side, one job per call
    // ======================================================================
    task automatic run_job(input int idx);
        int n;
        int k;
        int outs;
        int errs_before;
        n           = JOB_N[idx];
        k           = JOB_K[idx];
        outs        = outputs_for(n, k);
        exp_tiles   = tiles_for(n, k);
        errs_before = errors;
        @(posedge clk);
        #1;
        cfg_n    = N_W'(n);
        cfg_k    = K_W'(k);
        host_req = 1'b1;
        @(negedge clk);
        while (!host_ack) @(negedge clk);
        check_eq("weight beats", w_beats, k * k);
        check_eq("input beats", in_beats, exp_tiles * TILE_SIZE);
        check_eq("tiles", tiles, exp_tiles);
        check_eq("output beats", out_beats, outs);   // All drained before ack
        check_eq("last tile outputs", tile_out, outs - (exp_tiles - 1) * TILE_SIZE);
        check_eq("agu.start pulses", starts, 1 + 3 * exp_tiles);
        check_eq("sa.clear pulses", clears, 1);
        @(posedge clk);
        #1;
        // Counters still hold this job, monitor runs only at negedge
        $display("Job %0d N=%0d K=%0d: %0d tiles, %0d outputs, %0d cycles, %s", idx, n, k,
                 tiles, out_beats, cycle_count, (errors == errs_before) ? "ok" : "mismatch");
        host_req = 1'b0;
        @(negedge clk);
        while (host_ack) @(negedge clk);
    endtask

    initial begin
        host_req = 1'b0;
        cfg_n    = '0;
        cfg_k    = '0;
        rx_valid = 1'b0;
        tx_ready = 1'b0;
        tile_ack = 1'b0;
        @(posedge rst_n);
        @(negedge clk);
        check_eq("state", 32'(state), 32'(S_IDLE));
        check_eq("host_ack", 32'(host_ack), 0);
        check_eq("rx_ready", 32'(rx_ready), 0);
        check_eq("tx_valid", 32'(tx_valid), 0);
        check_eq("tile_req", 32'(tile_req), 0);
        check_eq("last_tile", 32'(last_tile), 0);
        check_eq("agu", 32'(agu), 0);    // Mode IDLE, no start
        check_eq("mem", 32'(mem), 0);
        check_eq("sa", 32'(sa), 0);
        check_eq("cycle_count", 32'(cycle_count), 0);
        for (int i = 0; i < NUM_JOBS; i++) run_job(i);
        $display("Jobs %0d, checks %0d, errors %0d, assertion failures %0d",
                 NUM_JOBS, checks, errors, u_dut.u_props.fail_count);
        if (errors == 0 && u_dut.u_props.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog, four cycles per beat of all jobs plus slack
    initial begin
        int beats;
        int limit;
        beats = 0;
        for (int i = 0; i < NUM_JOBS; i++) begin
            beats += JOB_K[i] * JOB_K[i] + outputs_for(JOB_N[i], JOB_K[i]) +
                     tiles_for(JOB_N[i], JOB_K[i]) * TILE_SIZE;
        end
        limit = beats * 4 * CLK_PERIOD + 1000;
        #(limit);
        $display("Watchdog expired after %0d ns, the jobs did not complete", limit);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: project.f
src/conv_ctrl_pkg.sv
src/job_config.sv
src/stream_counters.sv
src/ctrl_fsm.sv
src/datapath_ctrl_decode.sv
src/conv_ctrl_top.sv
testbench/tb_clock_gen.sv
testbench/conv_ctrl_properties.sv
testbench/tb_conv_ctrl.sv

// File: Makefile
SIM      := verilator
TOP      := tb_conv_ctrl
FILELIST := project.f
FLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0
OBJ_DIR  := obj_dir
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(OBJ_DIR)
